// ==== project.f ====
+incdir+src
src/ooo_pkg.sv
src/inst_decoder.sv
src/rename_unit.sv
src/phys_reg_file.sv
src/alu.sv
src/alu_station.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
sim/tb_ooo_core.sv

// ==== Makefile ====
TOP := tb_ooo_core

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf obj_dir

// ==== sim/tb_ooo_core.sv ====
`include "ooo_params.svh"

module tb_ooo_core import ooo_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_SEED     = `LOG_REGS - 1;
    localparam int N_RR       = 60;
    localparam int N_X0       = 4;
    localparam int N_RI       = 60;
    localparam int N_CHAIN    = 24;  // plus one independent op every other step
    localparam int N_BURST    = 3 * `ROB_DEPTH;
    localparam int N_MIX      = 42;
    localparam int N_TOTAL    = N_SEED + N_RR + N_X0 + N_RI + N_CHAIN + N_CHAIN / 2
                                + N_BURST + N_MIX;
    localparam int TIMEOUT_NS = (N_TOTAL * 40 + 200) * 40;

    // funct3 and funct7[5] per register-register op: add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] RR_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                          3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [9:0] RR_ALT     = 10'b0010000010;

    logic             clk;
    logic             arst_n;
    logic             inst_valid;
    logic [`XLEN-1:0] inst;
    logic             stall;
    logic             commit_valid;
    commit_t          commit;

    logic [`XLEN-1:0] shadow [`LOG_REGS];   // architectural state in program order
    commit_t          exp_q [$];
    int               n_accepted   = 0;
    int               n_committed  = 0;
    int               stall_cycles = 0;

    ooo_core_top u_ooo_core_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.rd !== exp.rd) begin
            $display("mismatch at time %0t: commit.rd got %0d expected %0d",
                     $time, got.rd, exp.rd);
            abort_run();
        end else if (got.value !== exp.value) begin
            $display("mismatch at time %0t: commit.value got %h expected %h (x%0d)",
                     $time, got.value, exp.value, exp.rd);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [`XLEN-1:0] ref_result(input logic [`XLEN-1:0] word);
        logic [`XLEN-1:0]        a;
        logic [`XLEN-1:0]        b;
        logic signed [`XLEN-1:0] sa;
        logic [`XLEN-1:0]        res;
        logic [4:0]              sh;
        logic                    imm_form;
        logic                    alt;
        imm_form = (word[6:0] == `OPC_OP_IMM);
        alt      = word[30];
        a        = shadow[word[19:15]];
        b        = imm_form ? {{20{word[31]}}, word[31:20]} : shadow[word[24:20]];
        sa       = a;
        sh       = b[4:0];
        case (word[14:12])
            3'd0:    res = (alt && !imm_form) ? a - b : a + b;
            3'd1:    res = a << sh;
            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
            3'd3:    res = {31'b0, a < b};
            3'd4:    res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = sa >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic [`XLEN-1:0] enc_r(input int k, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {RR_ALT[k] ? 7'h20 : 7'h00, rs2, rs1, RR_F3[k], rd, `OPC_OP};
    endfunction

    function automatic logic [`XLEN-1:0] enc_i(input logic [2:0] f3, input logic [11:0] imm,
                                               input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom;
        return r[4:0];
    endfunction

    function automatic logic [`XLEN-1:0] rand_rr(input logic [4:0] rd);
        return enc_r(int'($urandom_range(9, 0)), rd, rand_reg(), rand_reg());
    endfunction

    function automatic logic [`XLEN-1:0] rand_ri(input logic [4:0] rd, input logic [4:0] rs1);
        logic [31:0] r;
        logic [11:0] imm;
        r   = $urandom;
        imm = r[19:8];
        if (r[2:0] == 3'd1) begin
            imm[11:5] = 7'h00;
        end else if (r[2:0] == 3'd5) begin
            imm[11:5] = r[31] ? 7'h20 : 7'h00;  // srai or srli
        end
        return enc_i(r[2:0], imm, rd, rs1);
    endfunction

    // loads, stores and branches
    function automatic logic [`XLEN-1:0] rand_bad();
        logic [31:0] r;
        logic [6:0]  opc;
        r = $urandom;
        case ($urandom_range(2, 0))
            0:       opc = 7'h03;
            1:       opc = 7'h23;
            default: opc = 7'h63;
        endcase
        return {r[31:7], opc};
    endfunction

    task automatic send_inst(input logic [`XLEN-1:0] word);
        bit      taken;
        commit_t exp;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= word;
            @(negedge clk);
            if (!stall) begin
                taken = 1'b1;
            end else begin
                @(posedge clk);
                inst_valid <= 1'b0;  // back off until the core drains
                do begin
                    stall_cycles++;
                    @(negedge clk);
                end while (stall);
            end
        end
        if (word[6:0] == `OPC_OP || word[6:0] == `OPC_OP_IMM) begin
            exp.rd    = word[11:7];
            exp.value = ref_result(word);
            if (exp.rd != '0) begin
                shadow[exp.rd] = exp.value;
            end
            exp_q.push_back(exp);
            n_accepted++;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            n_committed++;
            if (exp_q.size() == 0) begin
                $display("error at time %0t: commit of x%0d with no instruction outstanding",
                         $time, commit.rd);
                abort_run();
            end else begin
                check_commit(commit, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("error: watchdog expired with %0d commits still outstanding", exp_q.size());
        abort_run();
    end

    initial begin
        logic [31:0] r;
        void'($urandom(32'h3acebba3));
        clk = 1'b0;
        arst_n     <= 1'b0;
        inst_valid <= 1'b0;
        inst       <= '0;
        for (int i = 0; i < `LOG_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        repeat (10) begin
            @(negedge clk);
            check_level("commit_valid", commit_valid, 1'b0);
            check_level("stall", stall, 1'b0);
        end

        // give every register a random value, negatives included
        for (int i = 1; i <= N_SEED; i++) begin
            r = $urandom;
            send_inst(enc_i(3'd0, r[11:0], 5'(i), 5'd0));
        end
        for (int i = 0; i < N_RR; i++) begin
            send_inst(rand_rr(rand_reg()));
        end

        send_inst(enc_i(3'd0, 12'd77, 5'd0, 5'd5));    // addi x0, x5, 77
        send_inst(enc_r(0, 5'd6, 5'd0, 5'd0));         // add x6, x0, x0
        send_inst(enc_r(8, 5'd7, 5'd0, 5'd3));
        send_inst(enc_i(3'd4, 12'hfff, 5'd8, 5'd0));   // xori x8, x0, -1
        for (int i = 0; i < N_RI; i++) begin
            send_inst(rand_ri(rand_reg(), rand_reg()));
        end

        // x10 chain with unrelated work in between
        for (int i = 0; i < N_CHAIN; i++) begin
            send_inst(enc_r(int'($urandom_range(9, 0)), 5'd10, 5'd10, rand_reg()));
            if (i % 2 == 1) begin
                send_inst(rand_ri(5'(20 + i % 8), 5'(21 + i % 7)));
            end
        end

        // one dispatch and one retire per cycle, so stall may stay low here
        r = 32'(stall_cycles);
        for (int i = 0; i < N_BURST; i++) begin
            if (i % 2 == 0) begin
                send_inst(rand_rr(rand_reg()));
            end else begin
                send_inst(rand_ri(rand_reg(), rand_reg()));
            end
        end
        $display("burst of %0d sent, %0d stall cycles", N_BURST, stall_cycles - int'(r));

        for (int i = 0; i < N_MIX; i++) begin
            if (i % 3 == 2) begin
                send_inst(rand_bad());
            end else begin
                send_inst(rand_rr(rand_reg()));
            end
        end

        @(posedge clk);
        inst_valid <= 1'b0;
        for (int i = 0; i < 100 && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);  // room for a stray commit
        $display("%0d accepted, %0d committed", n_accepted, n_committed);
        if (exp_q.size() != 0) begin
            $display("error: %0d accepted instructions never committed", exp_q.size());
            abort_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== src/ooo_core_top.sv ====
`include "ooo_params.svh"

module ooo_core_top import ooo_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    output logic             stall,
    output logic             commit_valid,
    output commit_t          commit
);
    decoded_inst_t dec;
    logic          legal;
    logic          accept;
    logic          rob_full;
    logic          rs_full;
    logic          cdb_valid;
    cdb_t          cdb;
    logic          release_valid;
    phys_tag_t     release_tag;
    phys_tag_t     src1_tag;
    phys_tag_t     src2_tag;
    phys_tag_t     new_tag;
    phys_tag_t     old_tag;
    operand_t      op1;
    operand_t      op2;
    rob_idx_t      tail_idx;

    assign stall  = rob_full | rs_full;
    assign accept = inst_valid & ~stall & legal;  // illegal opcodes vanish here

    inst_decoder u_inst_decoder (
        .inst  (inst),
        .dec   (dec),
        .legal (legal)
    );

    rename_unit u_rename_unit (
        .clk           (clk),
        .arst_n        (arst_n),
        .alloc         (accept),
        .rs1           (dec.rs1),
        .rs2           (dec.rs2),
        .rd            (dec.rd),
        .release_valid (release_valid),
        .release_tag   (release_tag),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .new_tag       (new_tag),
        .old_tag       (old_tag)
    );

    phys_reg_file u_phys_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd_tag1     (src1_tag),
        .rd_tag2     (src2_tag),
        .op1         (op1),
        .op2         (op2),
        .clear_valid (accept),
        .clear_tag   (new_tag),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb)
    );

    alu_station u_alu_station (
        .clk       (clk),
        .arst_n    (arst_n),
        .accept    (accept),
        .dec       (dec),
        .op1       (op1),
        .op2       (op2),
        .dest_tag  (new_tag),
        .rob_idx   (tail_idx),
        .full      (rs_full),
        .cdb_valid (cdb_valid),
        .cdb       (cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clk           (clk),
        .arst_n        (arst_n),
        .accept        (accept),
        .rd            (dec.rd),
        .old_tag       (old_tag),
        .tail_idx      (tail_idx),
        .full          (rob_full),
        .cdb_valid     (cdb_valid),
        .cdb           (cdb),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .release_valid (release_valid),
        .release_tag   (release_tag)
    );

endmodule

// ==== src/reorder_buffer.sv ====
`include "ooo_params.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              accept,
    input  logic [`LOG_W-1:0] rd,
    input  phys_tag_t         old_tag,
    output rob_idx_t          tail_idx,
    output logic              full,
    input  logic              cdb_valid,
    input  cdb_t              cdb,
    output logic              commit_valid,
    output commit_t           commit,
    output logic              release_valid,
    output phys_tag_t         release_tag
);
    localparam int CNT_W = `ROB_W + 1;

    logic [`LOG_W-1:0]     ent_rd [`ROB_DEPTH];
    phys_tag_t             ent_old [`ROB_DEPTH];
    logic [`XLEN-1:0]      ent_value [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done;
    rob_idx_t              head;
    rob_idx_t              tail;
    logic [CNT_W-1:0]      count;
    logic                  retire;

    assign tail_idx = tail;
    assign full     = (count == CNT_W'(`ROB_DEPTH));
    assign retire   = (count != '0) && done[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            done          <= '0;
            commit_valid  <= 1'b0;
            release_valid <= 1'b0;
        end else begin
            commit_valid  <= retire;
            release_valid <= retire;
            if (retire) begin
                done[head] <= 1'b0;  // slot is clean for its next owner
                head       <= head + 1'b1;
            end
            if (accept) begin
                tail <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            count <= count + CNT_W'(accept) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_rd[tail]  <= rd;
            ent_old[tail] <= old_tag;
        end
        if (cdb_valid) begin
            ent_value[cdb.rob_idx] <= cdb.value;
        end
        if (retire) begin
            commit.rd    <= ent_rd[head];
            commit.value <= ent_value[head];
            release_tag  <= ent_old[head];  // superseded mapping
        end
    end

endmodule

// ==== src/alu_station.sv ====
`include "ooo_params.svh"

module alu_station import ooo_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          accept,
    input  decoded_inst_t dec,
    input  operand_t      op1,
    input  operand_t      op2,
    input  phys_tag_t     dest_tag,
    input  rob_idx_t      rob_idx,
    output logic          full,
    output logic          cdb_valid,
    output cdb_t          cdb
);
    localparam int IDX_W = $clog2(`RS_DEPTH);
    localparam int CNT_W = $clog2(`RS_DEPTH + 1);

    typedef struct packed {
        alu_op_e          alu_op;
        logic             use_imm;
        logic [`XLEN-1:0] imm;
        operand_t         src1;
        operand_t         src2;
        phys_tag_t        dest;
        rob_idx_t         rob_idx;
    } rs_entry_t;

    rs_entry_t            q [`RS_DEPTH];    // collapsing queue, slot 0 is oldest
    rs_entry_t            woke [`RS_DEPTH];
    rs_entry_t            nq [`RS_DEPTH];
    rs_entry_t            new_entry;
    rs_entry_t            pick;
    logic [`RS_DEPTH-1:0] vld;
    logic [`RS_DEPTH-1:0] nv;
    logic [`RS_DEPTH-1:0] rdy;
    logic [IDX_W-1:0]     sel;
    logic                 fire;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     ins;
    logic [`XLEN-1:0]     alu_b;
    logic [`XLEN-1:0]     alu_y;

    function automatic operand_t wake(input operand_t op);
        operand_t w;
        w = op;
        if (!op.ready && cdb_valid && cdb.tag == op.tag) begin
            w.ready = 1'b1;
            w.value = cdb.value;
        end
        return w;
    endfunction

    assign new_entry = '{alu_op: dec.alu_op, use_imm: dec.use_imm, imm: dec.imm,
                         src1: op1, src2: op2, dest: dest_tag, rob_idx: rob_idx};

    // wakeup and oldest-ready pick
    always_comb begin
        count = '0;
        fire  = 1'b0;
        sel   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            woke[i]      = q[i];
            woke[i].src1 = wake(q[i].src1);
            woke[i].src2 = wake(q[i].src2);
            rdy[i] = vld[i] && woke[i].src1.ready && (woke[i].use_imm || woke[i].src2.ready);
            count  = count + CNT_W'(vld[i]);
            if (rdy[i]) begin
                fire = 1'b1;
                sel  = IDX_W'(i);  // lowest index wins
            end
        end
    end

    assign pick  = woke[sel];
    assign alu_b = pick.use_imm ? pick.imm : pick.src2.value;
    assign full  = (count == CNT_W'(`RS_DEPTH));

    alu u_alu (
        .a  (pick.src1.value),
        .b  (alu_b),
        .op (pick.alu_op),
        .y  (alu_y)
    );

    always_comb begin
        ins = count - CNT_W'(fire);
        for (int i = 0; i < `RS_DEPTH; i++) begin
            nq[i] = woke[i];
            nv[i] = vld[i];
        end
        if (fire) begin
            // close the gap behind the dispatched entry
            for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                if (i >= int'(sel)) begin
                    nq[i] = woke[i+1];
                    nv[i] = vld[i+1];
                end
            end
            nv[`RS_DEPTH-1] = 1'b0;
        end
        if (accept) begin
            nq[ins[IDX_W-1:0]] = new_entry;
            nv[ins[IDX_W-1:0]] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld       <= '0;
            cdb_valid <= 1'b0;
        end else begin
            vld       <= nv;
            cdb_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            q[i] <= nq[i];
        end
        if (fire) begin
            cdb.tag     <= pick.dest;
            cdb.rob_idx <= pick.rob_idx;
            cdb.value   <= alu_y;
        end
    end

endmodule

// ==== src/alu.sv ====
`include "ooo_params.svh"

module alu import ooo_pkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_e          op,
    output logic [`XLEN-1:0] y
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`XLEN-1){1'b0}}, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $signed(a) >>> shamt;  // sign fill
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

// ==== src/phys_reg_file.sv ====
`include "ooo_params.svh"

module phys_reg_file import ooo_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  phys_tag_t rd_tag1,
    input  phys_tag_t rd_tag2,
    output operand_t  op1,
    output operand_t  op2,
    input  logic      clear_valid,
    input  phys_tag_t clear_tag,
    input  logic      cdb_valid,
    input  cdb_t      cdb
);
    logic [`XLEN-1:0]      value [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;

    function automatic operand_t read_tag(input phys_tag_t tag);
        operand_t op;
        op.tag   = tag;
        op.ready = ready[tag];
        op.value = value[tag];
        if (tag == '0) begin
            op.ready = 1'b1;
            op.value = '0;
        end else if (cdb_valid && cdb.tag == tag) begin
            op.ready = 1'b1;       // bypass this cycle's result
            op.value = cdb.value;
        end
        return op;
    endfunction

    always_comb begin
        op1 = read_tag(rd_tag1);
        op2 = read_tag(rd_tag2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= '1;
            for (int i = 0; i < `PHYS_REGS; i++) begin
                value[i] <= '0;
            end
        end else begin
            if (cdb_valid) begin
                value[cdb.tag] <= cdb.value;
                ready[cdb.tag] <= 1'b1;
            end
            if (clear_valid) begin
                ready[clear_tag] <= 1'b0;  // freshly renamed destination
            end
        end
    end

endmodule

// ==== src/rename_unit.sv ====
`include "ooo_params.svh"

module rename_unit import ooo_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alloc,
    input  logic [`LOG_W-1:0] rs1,
    input  logic [`LOG_W-1:0] rs2,
    input  logic [`LOG_W-1:0] rd,
    input  logic              release_valid,
    input  phys_tag_t         release_tag,
    output phys_tag_t         src1_tag,
    output phys_tag_t         src2_tag,
    output phys_tag_t         new_tag,
    output phys_tag_t         old_tag
);
    localparam int FL_DEPTH = `PHYS_REGS - `LOG_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);

    phys_tag_t       rat [`LOG_REGS];
    phys_tag_t       free_list [FL_DEPTH];
    logic [FL_W-1:0] fl_head;
    logic [FL_W-1:0] fl_tail;

    // x0 keeps tag 0 forever
    assign src1_tag = rat[rs1];
    assign src2_tag = rat[rs2];
    assign new_tag  = free_list[fl_head];

    // x0 writes give their own tag back at commit
    assign old_tag  = (rd == '0) ? new_tag : rat[rd];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LOG_REGS; i++) begin
                rat[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= phys_tag_t'(`LOG_REGS + i);
            end
            fl_head <= '0;
            fl_tail <= '0;  // list starts full
        end else begin
            if (alloc) begin
                fl_head <= fl_head + 1'b1;
                if (rd != '0) begin
                    rat[rd] <= new_tag;
                end
            end
            // never overruns, in-flight count is bounded by the ROB
            if (release_valid) begin
                free_list[fl_tail] <= release_tag;
                fl_tail            <= fl_tail + 1'b1;
            end
        end
    end

endmodule

// ==== src/inst_decoder.sv ====
`include "ooo_params.svh"

module inst_decoder import ooo_pkg::*; (
    input  logic [`XLEN-1:0] inst,
    output decoded_inst_t    dec,
    output logic             legal
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       is_op_imm;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign is_op     = (opcode == `OPC_OP);
    assign is_op_imm = (opcode == `OPC_OP_IMM);

    always_comb begin
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.use_imm = is_op_imm;
        dec.imm     = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        case (funct3)
            3'b000:  dec.alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD; // no subi
            3'b001:  dec.alu_op = ALU_SLL;
            3'b010:  dec.alu_op = ALU_SLT;
            3'b011:  dec.alu_op = ALU_SLTU;
            3'b100:  dec.alu_op = ALU_XOR;
            3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  dec.alu_op = ALU_OR;
            default: dec.alu_op = ALU_AND;
        endcase

        legal = 1'b0;
        if (is_op) begin
            legal = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (is_op_imm) begin
            case (funct3)
                3'b001:  legal = (funct7 == 7'h00);
                3'b101:  legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                default: legal = 1'b1;  // upper imm bits are payload
            endcase
        end
    end

endmodule

// ==== src/ooo_pkg.sv ====
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef logic [`PHYS_W-1:0] phys_tag_t;
    typedef logic [`ROB_W-1:0]  rob_idx_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic [`LOG_W-1:0] rd;
        logic [`LOG_W-1:0] rs1;
        logic [`LOG_W-1:0] rs2;
        logic              use_imm;
        logic [`XLEN-1:0]  imm;     // sign-extended I-type
    } decoded_inst_t;

    typedef struct packed {
        logic             ready;
        phys_tag_t        tag;
        logic [`XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        phys_tag_t        tag;
        rob_idx_t         rob_idx;
        logic [`XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic [`LOG_W-1:0] rd;
        logic [`XLEN-1:0]  value;
    } commit_t;

endpackage

// ==== src/ooo_params.svh ====
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

`define XLEN        32
`define LOG_REGS    32
`define LOG_W       5
`define PHYS_REGS   64
`define PHYS_W      6
`define ROB_DEPTH   16
`define ROB_W       4
`define RS_DEPTH    8

// major opcodes handled by the core
`define OPC_OP      7'h33
`define OPC_OP_IMM  7'h13

`endif
